// File: flist.f
verilog/cnn_cfg_pkg.sv
verilog/cnn_state_pkg.sv
verilog/weight_dma.sv
verilog/fc_weight_ram.sv
verilog/conv_pool_unit.sv
verilog/fc_classifier.sv
verilog/cnn_core_top.sv
tests/tb_cnn_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cnn core testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_cnn_core \
  -f flist.f -Mdir obj_dir \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_cnn_core > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// File: tests/tb_cnn_core.sv
`timescale 1ns/1ps

module tb_cnn_core;

  logic                            clk;
  logic                            rst_n;
  logic                            i_start;
  logic [cnn_cfg_pkg::WORD_W-1:0]  i_sram_weight;
  logic [cnn_cfg_pkg::PIX_W-1:0]   i_pixel;
  logic                            i_pixel_valid;
  logic                            o_data_ready;
  logic                            o_dma_finish;
  logic [cnn_cfg_pkg::ADDR_W-1:0]  o_sram_weight_addr;
  logic [cnn_cfg_pkg::CLASS_W-1:0] o_result_data;
  logic                            o_result_data_valid;

  logic [cnn_cfg_pkg::WORD_W-1:0] sram [cnn_cfg_pkg::WEIGHT_WORDS];  // external weight memory
  int          tap_w   [cnn_cfg_pkg::TAP_N];          // signed copies of what was loaded
  int          fc_w    [cnn_cfg_pkg::FC_WEIGHT_LEN];
  int          row_pix [cnn_cfg_pkg::IMG_LEN];
  int          exp_q   [$];                           // expected classes, oldest first
  int          mem_addr_q;                            // address seen one cycle ago
  int          errors;
  int          checks;
  int          result_cnt;
  string       test_name;
  logic [31:0] lcg_state;

  cnn_core_top UUT (
    .clk                 (clk),
    .rst_n               (rst_n),
    .i_start             (i_start),
    .i_sram_weight       (i_sram_weight),
    .i_pixel             (i_pixel),
    .i_pixel_valid       (i_pixel_valid),
    .o_data_ready        (o_data_ready),
    .o_dma_finish        (o_dma_finish),
    .o_sram_weight_addr  (o_sram_weight_addr),
    .o_result_data       (o_result_data),
    .o_result_data_valid (o_result_data_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // memory model, one cycle read latency
  always @(posedge clk) begin
    #1;
    i_sram_weight = sram[mem_addr_q];
    if (int'(o_sram_weight_addr) < cnn_cfg_pkg::WEIGHT_WORDS) begin
      mem_addr_q = int'(o_sram_weight_addr);
    end else begin
      mem_addr_q = 0;
    end
  end

  // result compare, mid-cycle so the strobe is settled
  always @(negedge clk) begin
    if (rst_n && o_result_data_valid) begin
      result_cnt++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected result strobe (class %0d) with no row pending", o_result_data);
      end else begin
        check_value(test_name, exp_q.pop_front(), int'(o_result_data));
      end
    end
  end

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];  // upper bits, better period
  endfunction

  // expected class from taps, fc weights and the current row
  function automatic int ref_class();
    int act  [cnn_cfg_pkg::IMG_LEN - 2];
    int feat [cnn_cfg_pkg::FEAT_LEN];
    int sum;
    int best;
    int best_cls;
    for (int n = 0; n < cnn_cfg_pkg::IMG_LEN - 2; n++) begin
      sum = tap_w[0] * row_pix[n] + tap_w[1] * row_pix[n + 1] + tap_w[2] * row_pix[n + 2];
      if (sum < 0) begin
        act[n] = 0;                                   // relu
      end else begin
        act[n] = sum / (1 << cnn_cfg_pkg::FEAT_SHIFT);
        if (act[n] > 255) act[n] = 255;               // clamp
      end
    end
    for (int j = 0; j < cnn_cfg_pkg::FEAT_LEN; j++) begin
      feat[j] = (act[2 * j] > act[2 * j + 1]) ? act[2 * j] : act[2 * j + 1];
    end
    best     = 0;
    best_cls = 0;
    for (int c = 0; c < cnn_cfg_pkg::CLASS_N; c++) begin
      sum = 0;
      for (int f = 0; f < cnn_cfg_pkg::FEAT_LEN; f++) begin
        sum += fc_w[c * cnn_cfg_pkg::FEAT_LEN + f] * feat[f];
      end
      if (c == 0 || sum > best) begin                 // tie keeps lower class
        best     = sum;
        best_cls = c;
      end
    end
    return best_cls;
  endfunction

  task automatic put_weight(input int a, input int value);
    logic [15:0] r;
    r = rand16();
    sram[a] = {r[15:8], 8'(value)};                   // junk in the high byte
    if (a < cnn_cfg_pkg::TAP_N) begin
      tap_w[a] = int'($signed(sram[a][7:0]));
    end else begin
      fc_w[a - cnn_cfg_pkg::TAP_N] = int'($signed(sram[a][7:0]));
    end
  endtask

  task automatic random_weights();
    logic [15:0] r;
    for (int a = 0; a < cnn_cfg_pkg::WEIGHT_WORDS; a++) begin
      r = rand16();
      if (a < cnn_cfg_pkg::TAP_N) begin
        put_weight(a, int'(r[7:0] % 8'd48) - 12);     // taps -12..35, mostly positive
      end else begin
        put_weight(a, int'(r[7:0]));
      end
    end
  endtask

  // taps -1,0,1 and per-class constants; classes 1 and 2 tie on top
  task automatic crafted_weights();
    int cls_w [cnn_cfg_pkg::CLASS_N];
    cls_w = '{1, 3, 3, -2};
    put_weight(0, -1);
    put_weight(1, 0);
    put_weight(2, 1);
    for (int a = cnn_cfg_pkg::TAP_N; a < cnn_cfg_pkg::WEIGHT_WORDS; a++) begin
      put_weight(a, cls_w[(a - cnn_cfg_pkg::TAP_N) / cnn_cfg_pkg::FEAT_LEN]);
    end
  endtask

  task automatic fill_random_row();
    logic [15:0] r;
    for (int i = 0; i < cnn_cfg_pkg::IMG_LEN; i++) begin
      r = rand16();
      row_pix[i] = int'(r[7:0]);
    end
  endtask

  // one pixel every other cycle, 32 cycles per row
  task automatic send_row(input bit use_ref);
    if (use_ref) exp_q.push_back(ref_class());
    for (int i = 0; i < cnn_cfg_pkg::IMG_LEN; i++) begin
      @(posedge clk);
      #1;
      i_pixel       = 8'(row_pix[i]);
      i_pixel_valid = 1'b1;
      @(posedge clk);
      #1;
      i_pixel_valid = 1'b0;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // start strobe, address order, finish and ready timing
  task automatic run_load();
    int cycles;
    int addr_q [$];
    @(posedge clk);
    #1;
    i_start = 1'b1;
    @(posedge clk);                                   // edge that samples start
    #1;
    i_start = 1'b0;
    check_value("finish low after start", 0, int'(o_dma_finish));
    check_value("ready low after start", 0, int'(o_data_ready));
    cycles = 0;
    while (!o_dma_finish && cycles < 100) begin
      if (cycles < cnn_cfg_pkg::WEIGHT_WORDS) begin
        addr_q.push_back(int'(o_sram_weight_addr));  // one address per fetch cycle
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!o_dma_finish) begin
      errors++;
      $display("timeout: o_dma_finish never rose after start");
    end
    check_value("finish delay", cnn_cfg_pkg::WEIGHT_WORDS + 2, cycles);
    check_value("ready low with finish", 0, int'(o_data_ready));
    check_value("address count", cnn_cfg_pkg::WEIGHT_WORDS, addr_q.size());
    for (int a = 0; a < addr_q.size(); a++) begin
      check_value("address order", a, addr_q[a]);
    end
    @(posedge clk);
    #1;
    check_value("ready one cycle after finish", 1, int'(o_data_ready));
  endtask

  task automatic wait_results();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 200) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("timeout: %0d classifier results never arrived", exp_q.size());
      exp_q.delete();
    end
  endtask

  initial begin
    lcg_state     = 32'hc565;
    errors        = 0;
    checks        = 0;
    result_cnt    = 0;
    mem_addr_q    = 0;
    rst_n         = 1'b0;
    i_start       = 1'b0;
    i_sram_weight = '0;
    i_pixel       = '0;
    i_pixel_valid = 1'b0;
    test_name     = "reset";
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("reset o_data_ready", 0, int'(o_data_ready));
    check_value("reset o_dma_finish", 0, int'(o_dma_finish));
    check_value("reset o_result_data_valid", 0, int'(o_result_data_valid));

    test_name = "row before load";                   // conv unit still disabled
    fill_random_row();
    send_row(1'b0);
    idle_cycles(60);
    check_value("no result before load", 0, result_cnt);

    test_name = "first load";
    random_weights();
    run_load();

    test_name = "random rows";                       // back to back, two rows in flight
    for (int k = 0; k < 10; k++) begin
      fill_random_row();
      send_row(1'b1);
    end
    wait_results();
    check_value("random row result count", 10, result_cnt);

    test_name = "row during reload";
    random_weights();
    fill_random_row();
    fork
      run_load();
      begin
        repeat (2) @(posedge clk);                   // pixels land while finish is low
        send_row(1'b0);
      end
    join
    idle_cycles(60);
    check_value("no result during load", 10, result_cnt);

    test_name = "rows after reload";
    for (int k = 0; k < 4; k++) begin
      fill_random_row();
      send_row(1'b1);
    end
    wait_results();

    test_name = "tie rows";
    crafted_weights();
    run_load();
    for (int i = 0; i < cnn_cfg_pkg::IMG_LEN; i++) begin
      row_pix[i] = 16 * i;                           // rising, every feature is 2
    end
    exp_q.push_back(1);
    send_row(1'b0);
    for (int i = 0; i < cnn_cfg_pkg::IMG_LEN; i++) begin
      row_pix[i] = 240 - 16 * i;                     // falling, all conv negative
    end
    exp_q.push_back(0);
    send_row(1'b0);
    fill_random_row();
    send_row(1'b1);
    wait_results();
    idle_cycles(10);

    $display("checks: %0d, errors: %0d, results: %0d", checks, errors, result_cnt);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog/cnn_cfg_pkg.sv
package cnn_cfg_pkg;

  // row and layer dimensions
  localparam int IMG_LEN       = 16;                   // pixels per row
  localparam int TAP_N         = 3;                    // conv taps
  localparam int FEAT_LEN      = 7;                    // pooled features per row
  localparam int CLASS_N       = 4;                    // output classes
  localparam int FC_WEIGHT_LEN = CLASS_N * FEAT_LEN;   // 28 classifier weights
  localparam int WEIGHT_WORDS  = TAP_N + FC_WEIGHT_LEN; // 31 words per load

  // data widths
  localparam int PIX_W      = 8;   // pixel and feature, unsigned
  localparam int WGT_W      = 8;   // signed weight, low byte of a word
  localparam int WORD_W     = 16;  // external memory word
  localparam int ADDR_W     = 16;  // external memory address
  localparam int FC_ADDR_W  = 5;   // covers 28 ram entries
  localparam int ACC_W      = 20;  // signed mac and conv sum
  localparam int CLASS_W    = 2;   // result index
  localparam int FEAT_SHIFT = 4;   // scaling after relu

endpackage

// File: verilog/cnn_core_top.sv
`timescale 1ns/1ps

module cnn_core_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            i_start,
  input  logic [cnn_cfg_pkg::WORD_W-1:0]  i_sram_weight,
  input  logic [cnn_cfg_pkg::PIX_W-1:0]   i_pixel,
  input  logic                            i_pixel_valid,
  output logic                            o_data_ready,
  output logic                            o_dma_finish,
  output logic [cnn_cfg_pkg::ADDR_W-1:0]  o_sram_weight_addr,
  output logic [cnn_cfg_pkg::CLASS_W-1:0] o_result_data,
  output logic                            o_result_data_valid
);

  logic                              tap_we;    // dma to conv taps
  logic [1:0]                        tap_idx;
  logic                              fc_we;     // dma to classifier ram
  logic [cnn_cfg_pkg::FC_ADDR_W-1:0] fc_wr_addr;
  logic [cnn_cfg_pkg::WGT_W-1:0]     wgt_data;  // shared by both write ports
  logic [cnn_cfg_pkg::FC_ADDR_W-1:0] fc_rd_addr;
  logic [cnn_cfg_pkg::WGT_W-1:0]     fc_rd_data;
  logic [cnn_cfg_pkg::PIX_W-1:0]     feat;
  logic                              feat_valid;

  weight_dma u_weight_dma (
    .clk                (clk),
    .rst_n              (rst_n),
    .i_start            (i_start),
    .i_sram_weight      (i_sram_weight),
    .o_sram_weight_addr (o_sram_weight_addr),
    .o_tap_we           (tap_we),
    .o_tap_idx          (tap_idx),
    .o_fc_we            (fc_we),
    .o_fc_addr          (fc_wr_addr),
    .o_wgt_data         (wgt_data),
    .o_dma_finish       (o_dma_finish),
    .o_data_ready       (o_data_ready)
  );

  fc_weight_ram u_fc_weight_ram (
    .clk       (clk),
    .i_we      (fc_we),
    .i_wr_addr (fc_wr_addr),
    .i_wr_data (wgt_data),
    .i_rd_addr (fc_rd_addr),
    .o_rd_data (fc_rd_data)
  );

  conv_pool_unit u_conv_pool_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_enable      (o_dma_finish),  // pixels only after a complete load
    .i_pixel       (i_pixel),
    .i_pixel_valid (i_pixel_valid),
    .i_tap_we      (tap_we),
    .i_tap_idx     (tap_idx),
    .i_tap_data    (wgt_data),
    .o_feat        (feat),
    .o_feat_valid  (feat_valid)
  );

  fc_classifier u_fc_classifier (
    .clk                 (clk),
    .rst_n               (rst_n),
    .i_feat              (feat),
    .i_feat_valid        (feat_valid),
    .i_rd_data           (fc_rd_data),
    .o_rd_addr           (fc_rd_addr),
    .o_result_data       (o_result_data),
    .o_result_data_valid (o_result_data_valid)
  );

endmodule

// File: verilog/cnn_state_pkg.sv
package cnn_state_pkg;

  // weight load controller
  typedef enum logic [1:0] {
    DMA_IDLE  = 2'd0,  // wait for start
    DMA_FETCH = 2'd1,  // issue addresses 0..WEIGHT_WORDS-1
    DMA_DRAIN = 2'd2,  // last word on the bus
    DMA_DONE  = 2'd3   // finish held high
  } dma_state_t;

  // classifier controller
  typedef enum logic [1:0] {
    FC_IDLE = 2'd0,  // wait for a full row
    FC_ACC  = 2'd1,  // mac over one class
    FC_CMP  = 2'd2,  // class total vs best
    FC_OUT  = 2'd3   // result strobe
  } fc_state_t;

endpackage

// File: verilog/conv_pool_unit.sv
`timescale 1ns/1ps

module conv_pool_unit (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          i_enable,
  input  logic [cnn_cfg_pkg::PIX_W-1:0] i_pixel,
  input  logic                          i_pixel_valid,
  input  logic                          i_tap_we,
  input  logic [1:0]                    i_tap_idx,
  input  logic [cnn_cfg_pkg::WGT_W-1:0] i_tap_data,
  output logic [cnn_cfg_pkg::PIX_W-1:0] o_feat,
  output logic                          o_feat_valid
);

  logic signed [cnn_cfg_pkg::WGT_W-1:0] taps [cnn_cfg_pkg::TAP_N];
  logic [cnn_cfg_pkg::PIX_W-1:0]        win_old;   // pixel n-2, on tap 0
  logic [cnn_cfg_pkg::PIX_W-1:0]        win_mid;   // pixel n-1, on tap 1
  logic [cnn_cfg_pkg::PIX_W-1:0]        prev_val;  // first conv output of a pair
  logic [cnn_cfg_pkg::PIX_W-1:0]        conv_val;
  logic [cnn_cfg_pkg::PIX_W-1:0]        pool_max;
  logic [$clog2(cnn_cfg_pkg::IMG_LEN)-1:0] pix_cnt;
  logic                                 accept;
  logic                                 conv_on;
  logic                                 row_last;
  logic signed [cnn_cfg_pkg::ACC_W-1:0] conv_sum;
  logic signed [cnn_cfg_pkg::ACC_W-1:0] scaled;

  assign accept   = i_enable && i_pixel_valid;  // no pixels taken during a load
  assign conv_on  = int'(pix_cnt) >= cnn_cfg_pkg::TAP_N - 1;  // window full
  assign row_last = int'(pix_cnt) == cnn_cfg_pkg::IMG_LEN - 1;

  // pixels zero-extended so they stay positive in the signed mac
  assign conv_sum = taps[0] * $signed({1'b0, win_old})
                  + taps[1] * $signed({1'b0, win_mid})
                  + taps[2] * $signed({1'b0, i_pixel});
  assign scaled   = conv_sum >>> cnn_cfg_pkg::FEAT_SHIFT;

  always_comb begin
    if (conv_sum[cnn_cfg_pkg::ACC_W-1]) begin
      conv_val = '0;                                            // relu
    end else if (|scaled[cnn_cfg_pkg::ACC_W-1:cnn_cfg_pkg::PIX_W]) begin
      conv_val = '1;                                            // clamp to 255
    end else begin
      conv_val = scaled[cnn_cfg_pkg::PIX_W-1:0];
    end
  end

  assign pool_max = (conv_val > prev_val) ? conv_val : prev_val;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_cnt      <= '0;
      o_feat_valid <= 1'b0;
    end else begin
      // odd count closes a pair since conv index is count-2
      o_feat_valid <= accept && conv_on && pix_cnt[0];
      if (!i_enable) begin
        pix_cnt <= '0;                                          // realign rows after reload
      end else if (i_pixel_valid) begin
        pix_cnt <= row_last ? '0 : pix_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_tap_we) begin
      taps[i_tap_idx] <= i_tap_data;
    end
    if (accept) begin
      win_old <= win_mid;
      win_mid <= i_pixel;
      if (conv_on && !pix_cnt[0]) begin
        prev_val <= conv_val;                                   // hold first of pair
      end
      if (conv_on && pix_cnt[0]) begin
        o_feat <= pool_max;
      end
    end
  end

endmodule

// File: verilog/fc_classifier.sv
`timescale 1ns/1ps

module fc_classifier (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [cnn_cfg_pkg::PIX_W-1:0]     i_feat,
  input  logic                              i_feat_valid,
  input  logic [cnn_cfg_pkg::WGT_W-1:0]     i_rd_data,
  output logic [cnn_cfg_pkg::FC_ADDR_W-1:0] o_rd_addr,
  output logic [cnn_cfg_pkg::CLASS_W-1:0]   o_result_data,
  output logic                              o_result_data_valid
);

  cnn_state_pkg::fc_state_t state;
  logic [cnn_cfg_pkg::PIX_W-1:0]   cap_buf  [cnn_cfg_pkg::FEAT_LEN];  // row being streamed in
  logic [cnn_cfg_pkg::PIX_W-1:0]   work_buf [cnn_cfg_pkg::FEAT_LEN];  // row being classified
  logic [$clog2(cnn_cfg_pkg::FEAT_LEN)-1:0] cap_cnt;
  logic [$clog2(cnn_cfg_pkg::FEAT_LEN)-1:0] feat_idx;  // feature of the read issued now
  logic [$clog2(cnn_cfg_pkg::FEAT_LEN)-1:0] feat_d;    // feature of the returning weight
  logic [cnn_cfg_pkg::CLASS_W-1:0]  cls;
  logic [cnn_cfg_pkg::CLASS_W-1:0]  best_idx;
  logic                             mac_valid;          // weight on i_rd_data is live
  logic                             row_done;
  logic                             feat_last;
  logic                             cls_last;
  logic signed [cnn_cfg_pkg::ACC_W-1:0] prod;
  logic signed [cnn_cfg_pkg::ACC_W-1:0] acc;
  logic signed [cnn_cfg_pkg::ACC_W-1:0] acc_next;
  logic signed [cnn_cfg_pkg::ACC_W-1:0] best;

  assign row_done  = i_feat_valid && (int'(cap_cnt) == cnn_cfg_pkg::FEAT_LEN - 1);
  assign feat_last = int'(feat_idx) == cnn_cfg_pkg::FEAT_LEN - 1;
  assign cls_last  = int'(cls) == cnn_cfg_pkg::CLASS_N - 1;
  assign prod      = $signed(i_rd_data) * $signed({1'b0, work_buf[feat_d]});
  assign acc_next  = mac_valid ? acc + prod : acc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state               <= cnn_state_pkg::FC_IDLE;
      cap_cnt             <= '0;
      feat_idx            <= '0;
      cls                 <= '0;
      mac_valid           <= 1'b0;
      o_rd_addr           <= '0;
      o_result_data       <= '0;
      o_result_data_valid <= 1'b0;
    end else begin
      o_result_data_valid <= 1'b0;
      if (i_feat_valid) begin
        cap_cnt <= row_done ? '0 : cap_cnt + 1'b1;
      end
      case (state)
        cnn_state_pkg::FC_IDLE: begin
          if (row_done) begin                              // work buffer loads same edge
            state     <= cnn_state_pkg::FC_ACC;
            o_rd_addr <= '0;
            feat_idx  <= '0;
            cls       <= '0;
            mac_valid <= 1'b0;
          end
        end
        cnn_state_pkg::FC_ACC: begin
          o_rd_addr <= o_rd_addr + 1'b1;                   // weights are contiguous
          mac_valid <= 1'b1;
          if (feat_last) begin
            feat_idx <= '0;
            state    <= cnn_state_pkg::FC_CMP;
          end else begin
            feat_idx <= feat_idx + 1'b1;
          end
        end
        cnn_state_pkg::FC_CMP: begin
          if (cls_last) begin
            mac_valid <= 1'b0;
            state     <= cnn_state_pkg::FC_OUT;
          end else begin                                   // overlap f=0 read of next class
            cls       <= cls + 1'b1;
            o_rd_addr <= o_rd_addr + 1'b1;
            feat_idx  <= feat_idx + 1'b1;
            mac_valid <= 1'b1;
            state     <= cnn_state_pkg::FC_ACC;
          end
        end
        cnn_state_pkg::FC_OUT: begin
          o_result_data       <= best_idx;                 // held until next result
          o_result_data_valid <= 1'b1;
          state               <= cnn_state_pkg::FC_IDLE;
        end
        default: state <= cnn_state_pkg::FC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_feat_valid) begin
      cap_buf[cap_cnt] <= i_feat;
    end
    if (row_done) begin                                    // last feature bypasses capture
      for (int f = 0; f < cnn_cfg_pkg::FEAT_LEN - 1; f++) begin
        work_buf[f] <= cap_buf[f];
      end
      work_buf[cnn_cfg_pkg::FEAT_LEN-1] <= i_feat;
    end
    feat_d <= feat_idx;
    if (state == cnn_state_pkg::FC_IDLE || state == cnn_state_pkg::FC_CMP) begin
      acc <= '0;                                           // fresh sum per class
    end else begin
      acc <= acc_next;
    end
    // strictly greater, so a tie keeps the lower class
    if (state == cnn_state_pkg::FC_CMP && (cls == '0 || acc_next > best)) begin
      best     <= acc_next;
      best_idx <= cls;
    end
  end

endmodule

// File: verilog/fc_weight_ram.sv
`timescale 1ns/1ps

module fc_weight_ram (
  input  logic                              clk,
  input  logic                              i_we,
  input  logic [cnn_cfg_pkg::FC_ADDR_W-1:0] i_wr_addr,
  input  logic [cnn_cfg_pkg::WGT_W-1:0]     i_wr_data,
  input  logic [cnn_cfg_pkg::FC_ADDR_W-1:0] i_rd_addr,
  output logic [cnn_cfg_pkg::WGT_W-1:0]     o_rd_data
);

  // class-major layout, class c feature f at c*FEAT_LEN+f
  logic [cnn_cfg_pkg::WGT_W-1:0] mem [cnn_cfg_pkg::FC_WEIGHT_LEN];

  // write side, filled by the dma
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // read side, data one cycle after address
  always_ff @(posedge clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

// File: verilog/weight_dma.sv
`timescale 1ns/1ps

module weight_dma (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              i_start,
  input  logic [cnn_cfg_pkg::WORD_W-1:0]    i_sram_weight,
  output logic [cnn_cfg_pkg::ADDR_W-1:0]    o_sram_weight_addr,
  output logic                              o_tap_we,
  output logic [1:0]                        o_tap_idx,
  output logic                              o_fc_we,
  output logic [cnn_cfg_pkg::FC_ADDR_W-1:0] o_fc_addr,
  output logic [cnn_cfg_pkg::WGT_W-1:0]     o_wgt_data,
  output logic                              o_dma_finish,
  output logic                              o_data_ready
);

  cnn_state_pkg::dma_state_t state;
  logic [cnn_cfg_pkg::ADDR_W-1:0] fetch_addr;  // address on the port this cycle
  logic [cnn_cfg_pkg::ADDR_W-1:0] addr_d;      // address of the word now returning
  logic                           rd_valid;    // returning word is real
  logic                           last_addr;
  logic                           is_tap;

  assign last_addr          = int'(fetch_addr) == cnn_cfg_pkg::WEIGHT_WORDS - 1;
  assign o_sram_weight_addr = fetch_addr;

  // decode the returning word to its destination
  assign is_tap     = int'(addr_d) < cnn_cfg_pkg::TAP_N;
  assign o_tap_we   = rd_valid && is_tap;
  assign o_fc_we    = rd_valid && !is_tap;
  assign o_tap_idx  = addr_d[1:0];  // taps sit at 0..2
  assign o_fc_addr  = cnn_cfg_pkg::FC_ADDR_W'(int'(addr_d) - cnn_cfg_pkg::TAP_N);
  assign o_wgt_data = i_sram_weight[cnn_cfg_pkg::WGT_W-1:0];  // weight in low byte

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= cnn_state_pkg::DMA_IDLE;
      fetch_addr   <= '0;
      addr_d       <= '0;
      rd_valid     <= 1'b0;
      o_dma_finish <= 1'b0;
      o_data_ready <= 1'b0;
    end else begin
      addr_d       <= fetch_addr;                          // memory has 1 cycle latency
      rd_valid     <= (state == cnn_state_pkg::DMA_FETCH);
      o_data_ready <= o_dma_finish;                        // ready trails finish by one
      case (state)
        cnn_state_pkg::DMA_IDLE,
        cnn_state_pkg::DMA_DONE: begin
          if (i_start) begin                               // new load, drop both levels
            state        <= cnn_state_pkg::DMA_FETCH;
            fetch_addr   <= '0;
            o_dma_finish <= 1'b0;
            o_data_ready <= 1'b0;
          end else if (state == cnn_state_pkg::DMA_DONE) begin
            o_dma_finish <= 1'b1;                          // held until next start
          end
        end
        cnn_state_pkg::DMA_FETCH: begin
          if (last_addr) begin
            state <= cnn_state_pkg::DMA_DRAIN;             // hold addr, wait for last word
          end else begin
            fetch_addr <= fetch_addr + 1'b1;
          end
        end
        cnn_state_pkg::DMA_DRAIN: state <= cnn_state_pkg::DMA_DONE;
        default:                  state <= cnn_state_pkg::DMA_IDLE;
      endcase
    end
  end

endmodule
